/* rtl/ntm_fixed_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// NTM fixed-point vector types
// Word type, element result beat and FSM state encodings shared by the
// vector multiplier, the scalar multiplier and the dot accumulator
////////////////////////////////////////////////////////////////////////////

package ntm_fixed_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Word format
  ////////////////////////////////////////////////////////////////////////////

  // Widest word the datapath can carry
  // Modules work on the low DATA_SIZE bits and sign-extend the rest
  localparam int FX_WIDTH_MAX = 64;

  // Signed fixed-point word, Q(DATA_SIZE-FRAC_BITS).FRAC_BITS in low bits
  typedef logic signed [FX_WIDTH_MAX-1:0] fx_word_t;

  // One element result on its way to the accumulator and the outputs
  typedef struct packed {
    fx_word_t value;
    // Final element of the vector
    logic     last;
  } prod_beat_t;

  ////////////////////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////////////////////

  // Vector sequencer
  typedef enum logic [1:0] {
    VEC_IDLE    = 2'd0,
    VEC_COLLECT = 2'd1,
    VEC_WAIT    = 2'd2
  } vec_state_e;

  // Scalar shift-add multiplier
  typedef enum logic [1:0] {
    MUL_IDLE  = 2'd0,
    MUL_SHIFT = 2'd1,
    MUL_DONE  = 2'd2
  } mul_state_e;

endpackage

/* rtl/ntm_vector_dot_top.sv */
////////////////////////////////////////////////////////////////////////////
// NTM vector dot product block
// Element-wise fixed-point products streamed out per element, plus the
// dot product of the vector one cycle after READY
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ntm_vector_dot_top
  import ntm_fixed_pkg::*;
#(
  parameter int DATA_SIZE    = 16,
  parameter int FRAC_BITS    = 8,
  parameter int CONTROL_SIZE = 4
) (
  input  logic                    CLK,
  input  logic                    RST,

  // Control
  input  logic                    START,
  input  logic [CONTROL_SIZE-1:0] SIZE_IN,
  output logic                    READY,

  // Operands
  input  fx_word_t                DATA_A_IN,
  input  logic                    DATA_A_IN_ENABLE,
  input  fx_word_t                DATA_B_IN,
  input  logic                    DATA_B_IN_ENABLE,

  // Element products
  output prod_beat_t              PROD_OUT,
  output logic                    PROD_ENABLE,

  // Dot product
  output fx_word_t                DOT_OUT,
  output logic                    DOT_ENABLE
);

  // Beat stream shared by the outputs and the accumulator
  prod_beat_t prod_beat;
  logic       prod_enable;

  assign PROD_OUT    = prod_beat;
  assign PROD_ENABLE = prod_enable;

  // Element sequencer and multiplier
  vector_fixed_multiplier #(
    .DATA_SIZE   (DATA_SIZE),
    .FRAC_BITS   (FRAC_BITS),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) i_vec_mul (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .SIZE_IN         (SIZE_IN),
    .READY           (READY),
    .DATA_A_IN       (DATA_A_IN),
    .DATA_A_IN_ENABLE(DATA_A_IN_ENABLE),
    .DATA_B_IN       (DATA_B_IN),
    .DATA_B_IN_ENABLE(DATA_B_IN_ENABLE),
    .prod_beat       (prod_beat),
    .prod_enable     (prod_enable)
  );

  // Dot sum over the same beats
  vector_dot_accumulator #(
    .DATA_SIZE(DATA_SIZE)
  ) i_dot_acc (
    .CLK        (CLK),
    .RST        (RST),
    .prod_beat  (prod_beat),
    .prod_enable(prod_enable),
    .DOT_OUT    (DOT_OUT),
    .DOT_ENABLE (DOT_ENABLE)
  );

endmodule

/* rtl/scalar_fixed_multiplier.sv */
////////////////////////////////////////////////////////////////////////////
// Scalar fixed-point multiplier
// Sequential shift-add over DATA_SIZE cycles on operand magnitudes,
// truncates FRAC_BITS toward zero, restores the sign and wraps
// Result and ready arrive exactly DATA_SIZE+1 cycles after start
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scalar_fixed_multiplier
  import ntm_fixed_pkg::*;
#(
  parameter int DATA_SIZE = 16,
  parameter int FRAC_BITS = 8
) (
  input  logic     CLK,
  input  logic     RST,
  input  logic     start,
  input  fx_word_t data_a,
  input  fx_word_t data_b,
  output logic     ready,
  output fx_word_t result
);

  // Counter wide enough to hold DATA_SIZE-1
  localparam int CNT_W = $clog2(DATA_SIZE + 1);

  // Word format sanity
  if (DATA_SIZE > FX_WIDTH_MAX || FRAC_BITS >= DATA_SIZE) begin : g_bad_format
    $error("scalar_fixed_multiplier: unsupported DATA_SIZE/FRAC_BITS");
  end

  mul_state_e state;
  logic [CNT_W-1:0] bit_cnt;

  // Operand view in the active word width
  logic [DATA_SIZE-1:0] a_word;
  logic [DATA_SIZE-1:0] b_word;
  logic [DATA_SIZE-1:0] mag_a;
  logic [DATA_SIZE-1:0] mag_b;

  // Shift-add datapath
  logic [2*DATA_SIZE-1:0] acc;
  logic [2*DATA_SIZE-1:0] mcand;
  logic [DATA_SIZE-1:0]   mplier;
  logic                   neg;

  // Output shaping
  logic [2*DATA_SIZE-1:0]      prod_shift;
  logic [DATA_SIZE-1:0]        mag_trunc;
  logic signed [DATA_SIZE-1:0] wrapped;

  assign a_word = data_a[DATA_SIZE-1:0];
  assign b_word = data_b[DATA_SIZE-1:0];

  // Magnitudes; most negative value maps to 2^(DATA_SIZE-1), still fits
  assign mag_a = a_word[DATA_SIZE-1] ? (~a_word + 1'b1) : a_word;
  assign mag_b = b_word[DATA_SIZE-1] ? (~b_word + 1'b1) : b_word;

  // Shifting the magnitude truncates toward zero
  assign prod_shift = acc >> FRAC_BITS;
  assign mag_trunc  = prod_shift[DATA_SIZE-1:0];
  assign wrapped    = neg ? (~mag_trunc + 1'b1) : mag_trunc;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= MUL_IDLE;
      bit_cnt <= '0;
      ready   <= 1'b0;
      result  <= '0;
    end else begin
      // Single-cycle pulse
      ready <= 1'b0;
      case (state)
        MUL_IDLE: begin
          if (start) begin
            bit_cnt <= '0;
            state   <= MUL_SHIFT;
          end
        end
        MUL_SHIFT: begin
          // Bit 0 went in at start, one more multiplier bit per cycle
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(DATA_SIZE - 2)) begin
            state <= MUL_DONE;
          end
        end
        MUL_DONE: begin
          // Sign-extend the wrapped word into the full bus width
          result <= fx_word_t'(wrapped);
          ready  <= 1'b1;
          state  <= MUL_IDLE;
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == MUL_IDLE && start) begin
      // Multiplier bit 0 handled in the start cycle
      acc    <= mag_b[0] ? (2*DATA_SIZE)'(mag_a) : '0;
      mcand  <= (2*DATA_SIZE)'(mag_a) << 1;
      mplier <= mag_b >> 1;
      // Negative when exactly one operand is negative
      neg    <= a_word[DATA_SIZE-1] ^ b_word[DATA_SIZE-1];
    end else if (state == MUL_SHIFT) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Ready only after a full shift phase from an accepted start
  assert property (@(posedge CLK) disable iff (RST)
    ready |-> $past(start && state == MUL_IDLE, DATA_SIZE + 1))
    else $error("scalar_fixed_multiplier: ready off start timing");

endmodule

/* rtl/vector_dot_accumulator.sv */
////////////////////////////////////////////////////////////////////////////
// Vector dot accumulator
// Wrapping DATA_SIZE-bit running sum of the product beats of a vector,
// presented on DOT_OUT one cycle after the last beat
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vector_dot_accumulator
  import ntm_fixed_pkg::*;
#(
  parameter int DATA_SIZE = 16
) (
  input  logic       CLK,
  input  logic       RST,

  // Product beats
  input  prod_beat_t prod_beat,
  input  logic       prod_enable,

  // Dot result
  output fx_word_t   DOT_OUT,
  output logic       DOT_ENABLE
);

  // Running sum in the active word width
  logic signed [DATA_SIZE-1:0] sum;
  logic signed [DATA_SIZE-1:0] sum_next;

  // Next beat opens a new vector
  logic fresh;

  logic [DATA_SIZE-1:0] beat_word;

  assign beat_word = prod_beat.value[DATA_SIZE-1:0];

  // Restart from zero on the first beat, wrap on overflow
  assign sum_next = (fresh ? '0 : sum) + beat_word;

  ////////////////////////////////////////////////////////////////////////////
  // Accumulate
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum        <= '0;
      fresh      <= 1'b1;
      DOT_OUT    <= '0;
      DOT_ENABLE <= 1'b0;
    end else begin
      DOT_ENABLE <= prod_enable && prod_beat.last;
      if (prod_enable) begin
        sum   <= sum_next;
        fresh <= prod_beat.last;
        if (prod_beat.last) begin
          // Sign-extend into the bus word
          DOT_OUT <= fx_word_t'(sum_next);
        end
      end
    end
  end

  // Only the low word is summed, the rest of the bus must be its sign
  assert property (@(posedge CLK) disable iff (RST)
    prod_enable |-> prod_beat.value == fx_word_t'($signed(beat_word)))
    else $error("vector_dot_accumulator: beat not sign-extended");

endmodule

/* rtl/vector_fixed_multiplier.sv */
////////////////////////////////////////////////////////////////////////////
// Vector fixed-point multiplier
// Gathers the A and B operand of each element in any order, runs the
// scalar multiplier per element and emits one product beat per element
// READY pulses together with the beat of the final element
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vector_fixed_multiplier
  import ntm_fixed_pkg::*;
#(
  parameter int DATA_SIZE    = 16,
  parameter int FRAC_BITS    = 8,
  parameter int CONTROL_SIZE = 4
) (
  input  logic                    CLK,
  input  logic                    RST,

  // Control
  input  logic                    START,
  input  logic [CONTROL_SIZE-1:0] SIZE_IN,
  output logic                    READY,

  // Operand strobes
  input  fx_word_t                DATA_A_IN,
  input  logic                    DATA_A_IN_ENABLE,
  input  fx_word_t                DATA_B_IN,
  input  logic                    DATA_B_IN_ENABLE,

  // Element results
  output prod_beat_t              prod_beat,
  output logic                    prod_enable
);

  vec_state_e state;

  // Element counter and latched vector length minus one
  logic [CONTROL_SIZE-1:0] index_loop;
  logic [CONTROL_SIZE-1:0] size_m1;

  // Operand held flags
  logic a_held;
  logic b_held;

  // Operand registers
  fx_word_t op_a;
  fx_word_t op_b;

  // Scalar multiplier handshake
  logic     mul_start;
  logic     mul_ready;
  fx_word_t mul_result;

  logic is_last;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= VEC_IDLE;
      index_loop <= '0;
      size_m1    <= '0;
      a_held     <= 1'b0;
      b_held     <= 1'b0;
      mul_start  <= 1'b0;
    end else begin
      case (state)
        VEC_IDLE: begin
          if (START) begin
            // Size zero runs as a single element
            size_m1    <= (SIZE_IN == '0) ? '0 : SIZE_IN - CONTROL_SIZE'(1);
            index_loop <= '0;
            a_held     <= 1'b0;
            b_held     <= 1'b0;
            state      <= VEC_COLLECT;
          end
        end
        VEC_COLLECT: begin
          if (DATA_A_IN_ENABLE) begin
            a_held <= 1'b1;
          end
          if (DATA_B_IN_ENABLE) begin
            b_held <= 1'b1;
          end
          // Both operands held, kick the scalar unit next cycle
          if (a_held && b_held) begin
            mul_start <= 1'b1;
            state     <= VEC_WAIT;
          end
        end
        VEC_WAIT: begin
          mul_start <= 1'b0;
          a_held    <= 1'b0;
          b_held    <= 1'b0;
          if (mul_ready) begin
            if (index_loop == size_m1) begin
              state <= VEC_IDLE;
            end else begin
              index_loop <= index_loop + CONTROL_SIZE'(1);
              state      <= VEC_COLLECT;
            end
          end
        end
        default: state <= VEC_IDLE;
      endcase
    end
  end

  // First strobe of each operand wins until the element is launched
  always_ff @(posedge CLK) begin
    if (state == VEC_COLLECT && DATA_A_IN_ENABLE && !a_held) begin
      op_a <= DATA_A_IN;
    end
    if (state == VEC_COLLECT && DATA_B_IN_ENABLE && !b_held) begin
      op_b <= DATA_B_IN;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Beat output
  ////////////////////////////////////////////////////////////////////////////

  // Beat leaves in the same cycle as the scalar result
  assign prod_enable     = (state == VEC_WAIT) && mul_ready;
  assign is_last         = prod_enable && (index_loop == size_m1);
  assign prod_beat.value = mul_result;
  assign prod_beat.last  = is_last;
  assign READY           = is_last;

  scalar_fixed_multiplier #(
    .DATA_SIZE(DATA_SIZE),
    .FRAC_BITS(FRAC_BITS)
  ) i_scalar_mul (
    .CLK   (CLK),
    .RST   (RST),
    .start (mul_start),
    .data_a(op_a),
    .data_b(op_b),
    .ready (mul_ready),
    .result(mul_result)
  );

  // Every beat belongs to a multiply launched DATA_SIZE+1 cycles before
  assert property (@(posedge CLK) disable iff (RST)
    prod_enable |-> $past(mul_start, DATA_SIZE + 1))
    else $error("vector_fixed_multiplier: beat off multiplier timing");

endmodule

/* run.sh */
#!/bin/sh
# Build and run the vector dot testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module ntm_vector_dot_tb -o ntm_vector_dot_sim || { echo "Build failed"; exit 1; }

out=$(./obj_dir/ntm_vector_dot_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "No errors" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* tb/ntm_vector_dot_tb.sv */
////////////////////////////////////////////////////////////////////////////
// NTM vector dot product testbench
// Table of vectors applied to the top level one row at a time, element
// products, beat timing, last flag, READY and dot result checked against
// a fixed-point reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ntm_vector_dot_tb
  import ntm_fixed_pkg::*;
#(
  parameter int DATA_SIZE    = 16,
  parameter int FRAC_BITS    = 8,
  parameter int CONTROL_SIZE = 4
);

  localparam int NUM_ROWS   = 8;
  localparam int MAX_ELEMS  = 8;
  localparam int BEAT_LIMIT = 200;
  localparam int IDLE_LIMIT = 60;

  // DUT signals
  logic                    CLK;
  logic                    RST;
  logic                    start;
  logic [CONTROL_SIZE-1:0] size_in;
  fx_word_t                data_a;
  logic                    data_a_enable;
  fx_word_t                data_b;
  logic                    data_b_enable;
  logic                    ready;
  prod_beat_t              prod_out;
  logic                    prod_enable;
  fx_word_t                dot_out;
  logic                    dot_enable;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  // Order 0 sends A first, 1 sends B first, 2 sends both together
  string                names  [NUM_ROWS];
  int                   sizes  [NUM_ROWS];
  int                   orders [NUM_ROWS];
  int                   gaps   [NUM_ROWS];
  logic [DATA_SIZE-1:0] tab_a  [NUM_ROWS][MAX_ELEMS];
  logic [DATA_SIZE-1:0] tab_b  [NUM_ROWS][MAX_ELEMS];

  // Reference results of the row under test
  longint exp_prod[MAX_ELEMS];
  longint exp_dot;

  // Bookkeeping
  string       test_name;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  int          total_errors;
  bit          aborted;
  logic [15:0] lfsr_state;

  ntm_vector_dot_top #(
    .DATA_SIZE   (DATA_SIZE),
    .FRAC_BITS   (FRAC_BITS),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) i_dut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (start),
    .SIZE_IN         (size_in),
    .READY           (ready),
    .DATA_A_IN       (data_a),
    .DATA_A_IN_ENABLE(data_a_enable),
    .DATA_B_IN       (data_b),
    .DATA_B_IN_ENABLE(data_b_enable),
    .PROD_OUT        (prod_out),
    .PROD_ENABLE     (prod_enable),
    .DOT_OUT         (dot_out),
    .DOT_ENABLE      (dot_enable)
  );

  // 4 ns clock
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random operands and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one output bit per step
  function logic lfsr_take_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 16'hB400;
    return b;
  endfunction

  function logic [DATA_SIZE-1:0] random_word();
    logic [DATA_SIZE-1:0] w;
    w = '0;
    for (int k = 0; k < DATA_SIZE; k++) w = {w[DATA_SIZE-2:0], lfsr_take_bit()};
    return w;
  endfunction

  // Magnitude product, truncated toward zero, signed, wrapped to the word
  function automatic longint elem_product(logic [DATA_SIZE-1:0] a, logic [DATA_SIZE-1:0] b);
    longint               sa;
    longint               sb;
    longint               p;
    logic [DATA_SIZE-1:0] w;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    p = ((sa < 0) ? -sa : sa) * ((sb < 0) ? -sb : sb);
    p = p / (longint'(1) << FRAC_BITS);
    if ((sa < 0) != (sb < 0)) p = -p;
    w = DATA_SIZE'(p);
    return longint'($signed(w));
  endfunction

  task automatic compute_expected(input int r, input int n);
    longint               sum;
    logic [DATA_SIZE-1:0] w;
    sum = 0;
    for (int k = 0; k < n; k++) begin
      exp_prod[k] = elem_product(tab_a[r][k], tab_b[r][k]);
      sum = sum + exp_prod[k];
    end
    // Dot sum wraps like the products
    w = DATA_SIZE'(sum);
    exp_dot = longint'($signed(w));
  endtask

  task automatic set_row(input int r, input string nm, input int sz, input int ord,
                         input int gp, input bit rnd);
    names[r]   = nm;
    sizes[r]   = sz;
    orders[r]  = ord;
    gaps[r]    = gp;
    for (int k = 0; k < MAX_ELEMS; k++) begin
      tab_a[r][k] = rnd ? random_word() : '0;
      tab_b[r][k] = rnd ? random_word() : '0;
    end
  endtask

  task automatic set_elem(input int r, input int k,
                          input logic [DATA_SIZE-1:0] a, input logic [DATA_SIZE-1:0] b);
    tab_a[r][k] = a;
    tab_b[r][k] = b;
  endtask

  // Q8.8 rows: 0x0100 is 1.0, 0x0080 is 0.5
  task automatic fill_table();
    set_row(0, "unit_pos", 2, 0, 0, 1'b0);
    set_elem(0, 0, 16'h0100, 16'h0300);
    set_elem(0, 1, 16'h0080, 16'h0100);
    set_row(1, "neg_mixed_b_first", 4, 1, 2, 1'b0);
    set_elem(1, 0, 16'hFF00, 16'h0200);
    set_elem(1, 1, 16'hFF80, 16'hFF80);
    set_elem(1, 2, 16'h0180, 16'hFE00);
    set_elem(1, 3, 16'hFF00, 16'hFF00);
    set_row(2, "trunc_together", 3, 2, 0, 1'b0);
    set_elem(2, 0, 16'h0001, 16'h0080);
    set_elem(2, 1, 16'hFFFF, 16'h0080);
    set_elem(2, 2, 16'h0003, 16'hFF80);
    set_row(3, "max_wrap_gap", 3, 0, 3, 1'b0);
    set_elem(3, 0, 16'h7FFF, 16'h7FFF);
    set_elem(3, 1, 16'h8000, 16'h8000);
    set_elem(3, 2, 16'h7FFF, 16'h8000);
    // Size zero runs one element
    set_row(4, "size_zero", 0, 2, 0, 1'b0);
    set_elem(4, 0, 16'h0200, 16'h0280);
    // Back-to-back random vectors
    set_row(5, "rand_size1", 1, 2, 0, 1'b1);
    set_row(6, "rand_size3", 3, 1, 1, 1'b1);
    set_row(7, "rand_size8", 8, 0, 0, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input longint exp, input longint act);
    $display("** Error %s: %s expected %0d actual %0d", test_name, what, exp, act);
    test_errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("Failure in %s: %s", test_name, msg);
    test_errors++;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("PASS %s", test_name);
    end else begin
      tests_failed++;
      $display("FAIL %s (%0d mismatches)", test_name, test_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driving and waiting
  ////////////////////////////////////////////////////////////////////////////

  // Counts cycles after the sampling edge until a beat shows up
  task automatic wait_for_beat(output int cycles, output bit seen);
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < BEAT_LIMIT) begin
      @(negedge CLK);
      cycles++;
      if (prod_enable) seen = 1'b1;
    end
  endtask

  // Leaves off on the edge that samples the later strobe
  task automatic drive_operands(input int r, input int k);
    data_a <= fx_word_t'($signed(tab_a[r][k]));
    data_b <= fx_word_t'($signed(tab_b[r][k]));
    if (orders[r] == 2) begin
      data_a_enable <= 1'b1;
      data_b_enable <= 1'b1;
      @(posedge CLK);
      data_a_enable <= 1'b0;
      data_b_enable <= 1'b0;
    end else begin
      if (orders[r] == 0) data_a_enable <= 1'b1;
      else data_b_enable <= 1'b1;
      @(posedge CLK);
      data_a_enable <= 1'b0;
      data_b_enable <= 1'b0;
      repeat (gaps[r]) @(posedge CLK);
      if (orders[r] == 0) data_b_enable <= 1'b1;
      else data_a_enable <= 1'b1;
      @(posedge CLK);
      data_a_enable <= 1'b0;
      data_b_enable <= 1'b0;
    end
  endtask

  task automatic check_reset_idle();
    int cycles;
    test_name   = "reset_idle";
    test_errors = 0;
    @(negedge CLK);
    if (ready !== 1'b0) report_failure("READY not low after reset");
    if (prod_enable !== 1'b0) report_failure("PROD_ENABLE not low after reset");
    if (dot_enable !== 1'b0) report_failure("DOT_ENABLE not low after reset");
    if (dot_out !== '0) report_mismatch("DOT_OUT", 0, longint'(dot_out));
    // Strobes without START must be dropped
    @(posedge CLK);
    data_a        <= fx_word_t'(16'sh0100);
    data_b        <= fx_word_t'(16'sh0100);
    data_a_enable <= 1'b1;
    data_b_enable <= 1'b1;
    @(posedge CLK);
    data_a_enable <= 1'b0;
    data_b_enable <= 1'b0;
    for (cycles = 0; cycles < IDLE_LIMIT; cycles++) begin
      @(negedge CLK);
      if (prod_enable) report_failure("PROD_ENABLE without START");
    end
    finish_test();
  endtask

  task automatic run_row(input int r);
    int n;
    int cycles;
    bit seen;
    bit is_last;
    test_name   = names[r];
    test_errors = 0;
    n = (sizes[r] == 0) ? 1 : sizes[r];
    compute_expected(r, n);
    @(posedge CLK);
    start   <= 1'b1;
    size_in <= CONTROL_SIZE'(sizes[r]);
    @(posedge CLK);
    start <= 1'b0;
    for (int k = 0; k < n; k++) begin
      drive_operands(r, k);
      wait_for_beat(cycles, seen);
      if (!seen) begin
        report_failure($sformatf("no PROD_ENABLE for element %0d", k));
        aborted = 1'b1;
        finish_test();
        return;
      end
      is_last = (k == n - 1);
      if (cycles != DATA_SIZE + 3) report_mismatch($sformatf("latency %0d", k),
                                                   DATA_SIZE + 3, cycles);
      if (longint'(prod_out.value) != exp_prod[k])
        report_mismatch($sformatf("product %0d", k), exp_prod[k], longint'(prod_out.value));
      if (prod_out.last != is_last) report_mismatch($sformatf("last flag %0d", k),
                                                    is_last, prod_out.last);
      if (ready != is_last) report_mismatch($sformatf("READY at %0d", k), is_last, ready);
      if (dot_enable) report_failure("DOT_ENABLE during a product beat");
      @(posedge CLK);
    end
    // Dot result one cycle after READY
    @(negedge CLK);
    if (!dot_enable) report_failure("DOT_ENABLE missing after READY");
    if (longint'(dot_out) != exp_dot) report_mismatch("dot", exp_dot, longint'(dot_out));
    finish_test();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    RST           = 1'b1;
    start         = 1'b0;
    size_in       = '0;
    data_a        = '0;
    data_a_enable = 1'b0;
    data_b        = '0;
    data_b_enable = 1'b0;
    tests_run     = 0;
    tests_failed  = 0;
    total_errors  = 0;
    aborted       = 1'b0;
    lfsr_state    = 16'd53922;
    fill_table();
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    check_reset_idle();
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (!aborted) run_row(r);
    end
    $display("Summary: %0d tests run, %0d failed, %0d mismatches",
             tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verilog.f */
rtl/ntm_fixed_pkg.sv
rtl/scalar_fixed_multiplier.sv
rtl/vector_fixed_multiplier.sv
rtl/vector_dot_accumulator.sv
rtl/ntm_vector_dot_top.sv
tb/ntm_vector_dot_tb.sv
